// File: source/cmd_macros.svh
`ifndef CMD_MACROS_SVH
`define CMD_MACROS_SVH

// operand and result width
`define DATA_W 16

// fifo address width, capacity is 2**aw - 1
`define FIFO_AW 4

// flag thresholds in entries
`define ALMOST_EMPTY_MARGIN 2

// covers the three ops in flight between decode and push
`define ALMOST_FULL_MARGIN 4

// shift amount comes from the low bits of operand b
`define SHAMT_W 4

// width of the running result sequence number
`define SEQ_W 8

`endif

// File: source/common.sv
`default_nettype none

`include "cmd_macros.svh"

package common;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SHL  = 3'd5,
        OP_SHR  = 3'd6,
        OP_PASS = 3'd7
    } opcode_t;

    // host command, 39 bits
    typedef struct packed {
        opcode_t             opcode;
        logic [`DATA_W-1:0]  operand_a;
        logic [`DATA_W-1:0]  operand_b;
        logic [3:0]          tag;
    } cmd_t;

    // is_arith marks carry and overflow as meaningful
    typedef struct packed {
        cmd_t cmd;
        logic is_arith;
    } dec_op_t;

    // 31 bits, seq stamped in the last stage
    typedef struct packed {
        logic [3:0]          tag;
        logic [`DATA_W-1:0]  value;
        logic                carry;
        logic                zero;
        logic                overflow;
        logic [`SEQ_W-1:0]   seq;
    } result_t;

endpackage

`default_nettype wire

// File: source/fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_macros.svh"

module fifo #(
    parameter type payload_t = logic [`DATA_W-1:0],
    parameter int  ADDR_W    = `FIFO_AW,
    parameter int  AE_MARGIN = `ALMOST_EMPTY_MARGIN,
    parameter int  AF_MARGIN = `ALMOST_FULL_MARGIN
) (
    input  wire logic     clk_i,
    input  wire logic     reset_i,

    // write side
    input  wire payload_t write_data_i,
    input  wire logic     write_enable_i,

    // read side, data one cycle after the strobe
    input  wire logic     read_enable_i,
    output wire payload_t read_data_o,
    output wire logic     read_valid_o,

    output wire logic     fifo_empty_o,
    output wire logic     fifo_almost_empty_o,
    output wire logic     fifo_almost_full_o,
    output wire logic     fifo_full_o
);

typedef logic [ADDR_W-1:0] addr_t;

localparam int    DEPTH    = 1 << ADDR_W;
localparam addr_t CAPACITY = addr_t'(DEPTH - 1);
localparam addr_t AE_COUNT = addr_t'(AE_MARGIN);
localparam addr_t AF_COUNT = addr_t'(DEPTH - 1 - AF_MARGIN);

payload_t mem_r [DEPTH];
payload_t read_data_r;
logic     read_valid_r;
addr_t    read_ptr_r;
addr_t    write_ptr_r;

logic     empty_r;
logic     almost_empty_r;
logic     almost_full_r;
logic     full_r;

logic     write_ok_w;
logic     read_ok_w;
addr_t    read_ptr_w;
addr_t    write_ptr_w;
addr_t    count_w;

// full writes dropped, empty reads give no valid
assign write_ok_w = write_enable_i && !full_r;
assign read_ok_w  = read_enable_i && !empty_r;

always_comb begin
    write_ptr_w = write_ok_w ? write_ptr_r + addr_t'(1) : write_ptr_r;
    read_ptr_w  = read_ok_w ? read_ptr_r + addr_t'(1) : read_ptr_r;
    count_w     = write_ptr_w - read_ptr_w;
end

// pointers and flags
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        read_ptr_r     <= '0;
        write_ptr_r    <= '0;
        read_valid_r   <= 1'b0;
        empty_r        <= 1'b1;
        almost_empty_r <= 1'b1;
        almost_full_r  <= 1'b0;
        full_r         <= 1'b0;
    end else begin
        read_ptr_r     <= read_ptr_w;
        write_ptr_r    <= write_ptr_w;
        read_valid_r   <= read_ok_w;
        empty_r        <= (count_w == '0);
        almost_empty_r <= (count_w <= AE_COUNT);
        almost_full_r  <= (count_w >= AF_COUNT);
        full_r         <= (count_w == CAPACITY);
    end
end

// storage
always_ff @(posedge clk_i) begin
    if (write_ok_w) begin
        mem_r[write_ptr_r] <= write_data_i;
    end
    if (read_ok_w) begin
        read_data_r <= mem_r[read_ptr_r];
    end
end

assign read_data_o         = read_data_r;
assign read_valid_o        = read_valid_r;
assign fifo_empty_o        = empty_r;
assign fifo_almost_empty_o = almost_empty_r;
assign fifo_almost_full_o  = almost_full_r;
assign fifo_full_o         = full_r;

endmodule

`default_nettype wire

// File: source/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
    import common::*;
(
    input  wire logic    clk_i,
    input  wire logic    reset_i,

    // queue status
    input  wire logic    cmd_empty_i,
    input  wire logic    res_almost_full_i,

    // command fifo read side
    output wire logic    cmd_read_o,
    input  wire cmd_t    cmd_data_i,
    input  wire logic    cmd_valid_i,

    output wire dec_op_t op_o,
    output wire logic    op_valid_o
);

logic    pending_r;
logic    issue_w;
dec_op_t op_r;
logic    op_valid_r;

// only one pop outstanding, hold off near a full result queue
assign issue_w = !pending_r && !cmd_empty_i && !res_almost_full_i;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        pending_r  <= 1'b0;
        op_valid_r <= 1'b0;
    end else begin
        if (issue_w) begin
            pending_r <= 1'b1;
        end else if (cmd_valid_i) begin
            pending_r <= 1'b0;
        end
        op_valid_r <= cmd_valid_i;
    end
end

// decoded op register
always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
        op_r.cmd      <= cmd_data_i;
        op_r.is_arith <= (cmd_data_i.opcode == OP_ADD) ||
                         (cmd_data_i.opcode == OP_SUB);
    end
end

assign cmd_read_o = issue_w;
assign op_o       = op_r;
assign op_valid_o = op_valid_r;

endmodule

`default_nettype wire

// File: source/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_macros.svh"

module alu_execute
    import common::*;
(
    input  wire logic    clk_i,
    input  wire logic    reset_i,

    input  wire dec_op_t op_i,
    input  wire logic    op_valid_i,

    output wire result_t res_o,
    output wire logic    res_valid_o
);

localparam int MSB = `DATA_W - 1;

logic [`DATA_W-1:0]  a_w;
logic [`DATA_W-1:0]  b_w;
logic [`SHAMT_W-1:0] shamt_w;
logic [`DATA_W:0]    wide_w;
logic [`DATA_W-1:0]  value_w;
logic                carry_w;
logic                overflow_w;

result_t res_r;
logic    res_valid_r;

assign a_w     = op_i.cmd.operand_a;
assign b_w     = op_i.cmd.operand_b;
assign shamt_w = op_i.cmd.operand_b[`SHAMT_W-1:0];

always_comb begin
    // extra bit is carry out, or borrow on subtract
    wide_w = {1'b0, a_w} + {1'b0, b_w};
    if (op_i.cmd.opcode == OP_SUB) begin
        wide_w = {1'b0, a_w} - {1'b0, b_w};
    end

    unique case (op_i.cmd.opcode)
        OP_ADD,
        OP_SUB:  value_w = wide_w[`DATA_W-1:0];
        OP_AND:  value_w = a_w & b_w;
        OP_OR:   value_w = a_w | b_w;
        OP_XOR:  value_w = a_w ^ b_w;
        OP_SHL:  value_w = a_w << shamt_w;
        OP_SHR:  value_w = a_w >> shamt_w;
        OP_PASS: value_w = a_w;
        default: value_w = '0;
    endcase

    // signed overflow, sign of b flipped for subtract
    overflow_w = ((a_w[MSB] == (b_w[MSB] ^ (op_i.cmd.opcode == OP_SUB))) &&
                  (value_w[MSB] != a_w[MSB])) && op_i.is_arith;
    carry_w    = wide_w[`DATA_W] && op_i.is_arith;
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        res_valid_r <= 1'b0;
    end else begin
        res_valid_r <= op_valid_i;
    end
end

// zero and seq are filled in by the next stage
always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
        res_r.tag      <= op_i.cmd.tag;
        res_r.value    <= value_w;
        res_r.carry    <= carry_w;
        res_r.zero     <= 1'b0;
        res_r.overflow <= overflow_w;
        res_r.seq      <= '0;
    end
end

assign res_o       = res_r;
assign res_valid_o = res_valid_r;

endmodule

`default_nettype wire

// File: source/result_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_macros.svh"

module result_pack
    import common::*;
(
    input  wire logic    clk_i,
    input  wire logic    reset_i,

    input  wire result_t res_i,
    input  wire logic    res_valid_i,

    // result fifo write side
    output wire result_t push_o,
    output wire logic    push_valid_o
);

logic [`SEQ_W-1:0] seq_r;
result_t           push_r;
logic              push_valid_r;

// seq wraps naturally at 8 bits
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        seq_r        <= '0;
        push_valid_r <= 1'b0;
    end else begin
        if (res_valid_i) begin
            seq_r <= seq_r + 1'b1;
        end
        push_valid_r <= res_valid_i;
    end
end

always_ff @(posedge clk_i) begin
    if (res_valid_i) begin
        push_r      <= res_i;
        push_r.zero <= (res_i.value == '0);
        push_r.seq  <= seq_r;
    end
end

assign push_o       = push_r;
assign push_valid_o = push_valid_r;

endmodule

`default_nettype wire

// File: source/cmd_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_unit_top
    import common::*;
(
    input  wire logic    clk_i,
    input  wire logic    reset_i,

    // host command side
    input  wire cmd_t    cmd_i,
    input  wire logic    cmd_write_i,
    output wire logic    cmd_full_o,

    // host result side
    input  wire logic    res_read_i,
    output wire result_t res_o,
    output wire logic    res_valid_o,
    output wire logic    res_empty_o
);

cmd_t    cmd_data_w;
logic    cmd_valid_w;
logic    cmd_read_w;
logic    cmd_empty_w;
logic    res_almost_full_w;
dec_op_t op_w;
logic    op_valid_w;
result_t alu_res_w;
logic    alu_valid_w;
result_t push_w;
logic    push_valid_w;

fifo #(.payload_t(cmd_t)) cmd_fifo (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .write_data_i        (cmd_i),
    .write_enable_i      (cmd_write_i),
    .read_enable_i       (cmd_read_w),
    .read_data_o         (cmd_data_w),
    .read_valid_o        (cmd_valid_w),
    .fifo_empty_o        (cmd_empty_w),
    .fifo_almost_empty_o (),
    .fifo_almost_full_o  (),
    .fifo_full_o         (cmd_full_o)
);

cmd_decode decode (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .cmd_empty_i       (cmd_empty_w),
    .res_almost_full_i (res_almost_full_w),
    .cmd_read_o        (cmd_read_w),
    .cmd_data_i        (cmd_data_w),
    .cmd_valid_i       (cmd_valid_w),
    .op_o              (op_w),
    .op_valid_o        (op_valid_w)
);

alu_execute execute (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .op_i        (op_w),
    .op_valid_i  (op_valid_w),
    .res_o       (alu_res_w),
    .res_valid_o (alu_valid_w)
);

result_pack pack (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .res_i        (alu_res_w),
    .res_valid_i  (alu_valid_w),
    .push_o       (push_w),
    .push_valid_o (push_valid_w)
);

// almost full margin keeps in-flight results from overflowing
fifo #(.payload_t(result_t)) res_fifo (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .write_data_i        (push_w),
    .write_enable_i      (push_valid_w),
    .read_enable_i       (res_read_i),
    .read_data_o         (res_o),
    .read_valid_o        (res_valid_o),
    .fifo_empty_o        (res_empty_o),
    .fifo_almost_empty_o (),
    .fifo_almost_full_o  (res_almost_full_w),
    .fifo_full_o         ()
);

endmodule

`default_nettype wire

// File: testbench/cmd_unit_props.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_unit_props (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic cmd_write_i,
    input wire logic cmd_full_i,
    input wire logic res_read_i,
    input wire logic res_valid_i,
    input wire logic res_empty_i
);

// count of failed assertions
int fail_count = 0;

// both queues come out of reset empty, nothing on the result port
reset_state: assert property (@(posedge clk_i)
    reset_i |=> (res_empty_i && !cmd_full_i && !res_valid_i))
    else begin
        $error("flags not at reset values one cycle after reset");
        fail_count++;
    end

read_gives_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (res_read_i && !res_empty_i) |=> res_valid_i)
    else begin
        $error("read of a non-empty result queue gave no valid");
        fail_count++;
    end

// no valid without a read taken on a non-empty queue
no_spurious_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    !(res_read_i && !res_empty_i) |=> !res_valid_i)
    else begin
        $error("valid result without a matching read");
        fail_count++;
    end

// result queue only empties through a host read
empty_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(res_empty_i) |-> $past(res_read_i))
    else begin
        $error("result queue went empty without a read");
        fail_count++;
    end

full_after_write: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cmd_full_i) |-> $past(cmd_write_i))
    else begin
        $error("command queue went full without a write");
        fail_count++;
    end

endmodule

bind cmd_unit_top cmd_unit_props port_checks (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_write_i (cmd_write_i),
    .cmd_full_i  (cmd_full_o),
    .res_read_i  (res_read_i),
    .res_valid_i (res_valid_o),
    .res_empty_i (res_empty_o)
);

`default_nettype wire

// File: testbench/cmd_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmd_macros.svh"

module cmd_unit_tb
    import common::*;
();

localparam int RESET_CYCLES = 10;
localparam int OPCODE_CMDS  = 32;
localparam int SEQ_CMDS     = 300;
localparam int FILL_CMDS    = 40;
// about ten cycles per command at worst, plus fill settle and drains
localparam int TIMEOUT_CYCLES = RESET_CYCLES + 10 * (OPCODE_CMDS + SEQ_CMDS + FILL_CMDS) + 270;
localparam int MAX_U = (1 << `DATA_W) - 1;
localparam int MAX_S = (1 << (`DATA_W - 1)) - 1;
localparam int MIN_S = -(1 << (`DATA_W - 1));

logic    clk_i;
logic    reset_i;
cmd_t    cmd_i;
logic    cmd_write_i;
logic    cmd_full_o;
logic    res_read_i;
result_t res_o;
logic    res_valid_o;
logic    res_empty_o;

result_t           exp_q[$];
logic [`SEQ_W-1:0] model_seq = '0;
int                accepted = 0;
int                read_hits = 0;
int                errors = 0;
int                checks = 0;
int                tests_run = 0;
int                cycle_count = 0;
logic              wrap_seen = 1'b0;

cmd_unit_top DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_i       (cmd_i),
    .cmd_write_i (cmd_write_i),
    .cmd_full_o  (cmd_full_o),
    .res_read_i  (res_read_i),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_empty_o (res_empty_o)
);

initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
end

function automatic int total_errors();
    return errors + DUT.port_checks.fail_count;
endfunction

// expected result straight from the opcode rules
function automatic result_t model_result(input cmd_t c, input logic [`SEQ_W-1:0] seq);
    result_t r;
    int      a;
    int      b;
    int      full;
    int      wide;
    a = int'(c.operand_a);
    b = int'(c.operand_b);
    r = '0;
    r.tag = c.tag;
    r.seq = seq;
    case (c.opcode)
        OP_ADD: begin
            full = a + b;
            wide = int'($signed(c.operand_a)) + int'($signed(c.operand_b));
            r.value = full[`DATA_W-1:0];
            r.carry = (full > MAX_U);
            r.overflow = (wide > MAX_S) || (wide < MIN_S);
        end
        OP_SUB: begin
            full = a - b;
            wide = int'($signed(c.operand_a)) - int'($signed(c.operand_b));
            r.value = full[`DATA_W-1:0];
            // borrow
            r.carry = (a < b);
            r.overflow = (wide > MAX_S) || (wide < MIN_S);
        end
        OP_AND:  r.value = c.operand_a & c.operand_b;
        OP_OR:   r.value = c.operand_a | c.operand_b;
        OP_XOR:  r.value = c.operand_a ^ c.operand_b;
        OP_SHL:  r.value = c.operand_a << c.operand_b[`SHAMT_W-1:0];
        OP_SHR:  r.value = c.operand_a >> c.operand_b[`SHAMT_W-1:0];
        default: r.value = c.operand_a;
    endcase
    r.zero = (r.value == '0);
    return r;
endfunction

// corner values now and then so zero, carry and overflow get hit
function automatic logic [`DATA_W-1:0] pick_operand();
    case ($urandom_range(0, 5))
        0:       return '0;
        1:       return '1;
        2:       return {1'b1, {(`DATA_W - 1){1'b0}}};
        3:       return {1'b0, {(`DATA_W - 1){1'b1}}};
        default: return `DATA_W'($urandom);
    endcase
endfunction

function automatic cmd_t random_cmd(input opcode_t op);
    cmd_t c;
    c.opcode    = op;
    c.operand_a = pick_operand();
    c.operand_b = pick_operand();
    c.tag       = 4'($urandom);
    return c;
endfunction

task automatic compare_result(input result_t got);
    result_t want;
    checks++;
    if (exp_q.size() == 0) begin
        $display("result with tag %0h at %0t ns arrived with no command waiting for it",
                 got.tag, $time);
        errors++;
    end else begin
        want = exp_q.pop_front();
        if (got.seq == '0 && read_hits > 1) begin
            wrap_seen = 1'b1;
        end
        assert (got == want) else begin
            $display("FAIL %0t ns: tag %0h seq %0d got %h c%0b z%0b v%0b, want %h c%0b z%0b v%0b",
                     $time, want.tag, want.seq, got.value, got.carry, got.zero, got.overflow,
                     want.value, want.carry, want.zero, want.overflow);
            errors++;
        end
    end
endtask

// accepted writes feed the model, every valid result is checked
always @(posedge clk_i) begin
    if (!reset_i) begin
        if (cmd_write_i && !cmd_full_o) begin
            exp_q.push_back(model_result(cmd_i, model_seq));
            model_seq = model_seq + 1'b1;
            accepted++;
        end
        if (res_valid_o) begin
            read_hits++;
            compare_result(res_o);
        end
    end
end

always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end
end

task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (total_errors() == errors_before) begin
        $display("test %-8s ok", name);
    end else begin
        $display("test %-8s %0d errors", name, total_errors() - errors_before);
    end
endtask

task automatic drain();
    res_read_i <= 1'b1;
    @(posedge clk_i);
    while (exp_q.size() != 0) begin
        @(posedge clk_i);
    end
    res_read_i <= 1'b0;
endtask

task automatic run_stream(input int count, input bit cycle_ops);
    int      sent;
    opcode_t op;
    sent = 0;
    while (sent < count) begin
        @(posedge clk_i);
        res_read_i <= ($urandom_range(0, 3) != 0);
        if ($urandom_range(0, 2) == 0) begin
            op = cycle_ops ? opcode_t'(sent % 8) : opcode_t'($urandom_range(0, 7));
            cmd_i       <= random_cmd(op);
            cmd_write_i <= 1'b1;
            sent++;
        end else begin
            cmd_write_i <= 1'b0;
        end
    end
    @(posedge clk_i);
    cmd_write_i <= 1'b0;
    drain();
endtask

initial begin
    int errs;
    int fill_start;
    void'($urandom(45));
    reset_i     <= 1'b1;
    cmd_write_i <= 1'b0;
    cmd_i       <= '0;
    res_read_i  <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    report_test("reset", 0);

    errs = total_errors();
    run_stream(OPCODE_CMDS, 1'b1);
    report_test("opcodes", errs);

    errs = total_errors();
    run_stream(SEQ_CMDS, 1'b0);
    checks++;
    assert (wrap_seen) else begin
        $display("FAIL %0t ns: seq never wrapped back to zero", $time);
        errors++;
    end
    report_test("seq", errs);

    // no reads, so both queues back up
    errs = total_errors();
    fill_start = accepted;
    repeat (FILL_CMDS) begin
        @(posedge clk_i);
        cmd_i       <= random_cmd(opcode_t'($urandom_range(0, 7)));
        cmd_write_i <= 1'b1;
    end
    @(posedge clk_i);
    cmd_write_i <= 1'b0;
    repeat (20) @(posedge clk_i);
    checks++;
    assert (cmd_full_o && !res_empty_o) else begin
        $display("FAIL %0t ns: queues not backed up after %0d writes", $time, FILL_CMDS);
        errors++;
    end
    checks++;
    assert (accepted - fill_start < FILL_CMDS) else begin
        $display("FAIL %0t ns: all %0d writes taken by a full queue", $time, FILL_CMDS);
        errors++;
    end
    drain();
    report_test("fill", errs);

    errs = total_errors();
    repeat (10) @(posedge clk_i);
    checks++;
    assert (read_hits == accepted) else begin
        $display("FAIL %0t ns: %0d results read for %0d accepted commands",
                 $time, read_hits, accepted);
        errors++;
    end
    report_test("totals", errs);

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, total_errors());
    if (total_errors() == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/common.sv
source/fifo.sv
source/cmd_decode.sv
source/alu_execute.sv
source/result_pack.sv
source/cmd_unit_top.sv
testbench/cmd_unit_props.sv
testbench/cmd_unit_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module cmd_unit_tb \
    -f src.f -o cmd_unit_sim \
    && ./obj_dir/cmd_unit_sim +verilator+error+limit+1000 \
    | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
